// ==== src.f ====
+incdir+common
common/noc_pkg.sv
design/noc_router/noc_buffer.sv
design/noc_router/noc_out_arbiter.sv
design/noc_router/noc_router.sv
design/noc_mesh_2x2.sv
design/noc_tile_adapter.sv
design/system_2x2_noc.sv
verification/tb_system_2x2_noc.sv

// ==== verification/tb_system_2x2_noc.sv ====
// 2x2 noc system testbench
// random packet traffic between four tiles, checked against a reference
// model of expected messages per source and destination pair.

`timescale 1ns/100ps

`include "noc_macros.svh"

module tb_system_2x2_noc import noc_pkg::*; ();

   localparam int N_RAND      = 24;   // random messages per tile.
   localparam int N_HOT       = 6;    // messages per tile into tile 0.
   localparam int N_MSGS      = 16 + 4 * (N_RAND + N_HOT);
   localparam int WDOG_CYCLES = N_MSGS * (`NOC_MAX_PAYLOAD + 1) * 4 + 2000;
   localparam int W           = `NOC_FLIT_WIDTH;

   typedef struct packed {
      logic [1:0]       src;
      logic [7:0]       seq;
      logic [2:0]       len;
      logic [4*W-1:0]   words;   // word k in slice k.
   } exp_msg_t;

   logic           clk_i = 1'b0;
   logic           arst_n_i;
   logic [3:0]     tx_valid_i;
   logic [7:0]     tx_dest_i;
   logic [4*W-1:0] tx_data_i;
   logic [3:0]     tx_last_i;
   logic [3:0]     tx_ready_o;
   logic [3:0]     rx_valid_o;
   logic [7:0]     rx_src_o;
   logic [31:0]    rx_seq_o;
   logic [4*W-1:0] rx_data_o;
   logic [3:0]     rx_last_o;
   logic [3:0]     rx_ready_i;

   exp_msg_t    exp_q [16][$];   // index is src * 4 + dest.
   int          sent_cnt [4];
   int          pending;
   logic [31:0] rng_state;
   logic [31:0] ready_bits;
   logic        ready_rand;
   int          data_errs;
   int          hdr_errs;
   int          last_errs;
   int          other_errs;

   system_2x2_noc system_2x2_noc_i (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .tx_valid_i (tx_valid_i),
      .tx_dest_i  (tx_dest_i),
      .tx_data_i  (tx_data_i),
      .tx_last_i  (tx_last_i),
      .tx_ready_o (tx_ready_o),
      .rx_valid_o (rx_valid_o),
      .rx_src_o   (rx_src_o),
      .rx_seq_o   (rx_seq_o),
      .rx_data_o  (rx_data_o),
      .rx_last_o  (rx_last_o),
      .rx_ready_i (rx_ready_i)
   );

   always #4 clk_i = ~clk_i;   // 8 ns period.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // random numbers and reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [31:0] xorshift32(logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand_next();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // seq is the running packet count of the source, mod 256.
   function automatic exp_msg_t exp_msg(int src, int len, logic [4*W-1:0] words);
      exp_msg_t m;
      m.src   = 2'(src);
      m.seq   = 8'(sent_cnt[src] % 256);
      m.len   = 3'(len);
      m.words = words;
      return m;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // compare tasks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic check_flit(input int tile, input int idx, input flit_u got, input flit_u exp);
      if (got.raw !== exp.raw) begin
         data_errs++;
         $display("CHECK FAILED %0t ns: tile %0d word %0d data 0x%08h, expected 0x%08h",
                  $time, tile, idx, got.raw, exp.raw);
      end
   endtask

   task automatic check_hdr(input int tile, input logic [1:0] src, input logic [7:0] seq,
                            input logic [1:0] exp_src, input logic [7:0] exp_seq);
      if (src !== exp_src || seq !== exp_seq) begin
         hdr_errs++;
         $display("CHECK FAILED %0t ns: tile %0d src %0d seq %0d, expected src %0d seq %0d",
                  $time, tile, src, seq, exp_src, exp_seq);
      end
   endtask

   task automatic check_last(input int tile, input int idx, input logic got, input logic exp);
      if (got !== exp) begin
         last_errs++;
         $display("CHECK FAILED %0t ns: tile %0d word %0d last %b, expected %b",
                  $time, tile, idx, got, exp);
      end
   endtask

   task automatic check_ctrl(input logic [3:0] got, input logic [3:0] exp, input string what);
      if (got !== exp) begin
         other_errs++;
         $display("CHECK FAILED %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // tile transmit side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // called at 1 ns after an edge, returns at the same point.
   task automatic send_msg(input int src, input int dst, input int len);
      logic [4*W-1:0] words;
      logic           ok;
      words = '0;
      for (int k = 0; k < len; k++) begin
         words[k*W +: W] = rand_next();
      end
      exp_q[src*4 + dst].push_back(exp_msg(src, len, words));
      sent_cnt[src]++;
      pending++;
      tx_dest_i[src*2 +: 2] = 2'(dst);
      for (int k = 0; k < len; k++) begin
         tx_valid_i[src]       = 1'b1;
         tx_data_i[src*W +: W] = words[k*W +: W];
         tx_last_i[src]        = (k == len - 1);
         ok = 1'b0;
         while (!ok) begin
            @(negedge clk_i);
            ok = tx_ready_o[src];   // transfer on the coming edge.
            @(posedge clk_i);
            #1;
         end
      end
      tx_valid_i[src] = 1'b0;
      tx_last_i[src]  = 1'b0;
   endtask

   task automatic send_pairs(input int src);
      for (int d = 0; d < 4; d++) begin
         send_msg(src, d, 1);
      end
   endtask

   // hot sends everything to tile 0.
   task automatic send_random(input int src, input int n, input logic hot);
      logic [31:0] r;
      int          gap;
      for (int m = 0; m < n; m++) begin
         r   = rand_next();
         gap = int'(r[5:4]);
         send_msg(src, hot ? 0 : int'(r[1:0]), 1 + int'(r[3:2]));
         if (gap > 0) begin
            repeat (gap) @(posedge clk_i);
            #1;
         end
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // tile receive side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic rx_monitor(input int t);
      exp_msg_t   cur;
      logic       have_exp;
      logic       in_pkt;
      int         k;
      logic [1:0] src;
      flit_u      got;
      flit_u      exp_f;
      cur      = '0;
      have_exp = 1'b0;
      in_pkt   = 1'b0;
      k        = 0;
      forever begin
         @(negedge clk_i);
         if (arst_n_i && rx_valid_o[t] && rx_ready_i[t]) begin
            src = rx_src_o[t*2 +: 2];
            if (!in_pkt) begin
               in_pkt = 1'b1;
               k      = 0;
               if (exp_q[int'(src)*4 + t].size() == 0) begin
                  have_exp = 1'b0;
                  other_errs++;
                  $display("%0t ns: tile %0d received a packet from tile %0d that was never sent",
                           $time, t, src);
               end else begin
                  have_exp = 1'b1;
                  cur      = exp_q[int'(src)*4 + t].pop_front();
               end
            end
            if (have_exp) begin
               check_hdr(t, src, rx_seq_o[t*8 +: 8], cur.src, cur.seq);
               if (k < int'(cur.len)) begin
                  got.raw   = rx_data_o[t*W +: W];
                  exp_f.raw = cur.words[k*W +: W];
                  check_flit(t, k, got, exp_f);
                  check_last(t, k, rx_last_o[t], k == int'(cur.len) - 1);
               end else begin
                  other_errs++;
                  $display("%0t ns: tile %0d received more words than the packet from tile %0d holds",
                           $time, t, src);
               end
            end
            k++;
            if (rx_last_o[t]) begin
               in_pkt = 1'b0;
               if (have_exp) pending--;
            end
         end
      end
   endtask

   initial begin
      fork
         rx_monitor(0);
         rx_monitor(1);
         rx_monitor(2);
         rx_monitor(3);
      join
   end

   // random back-pressure on the tile receive ports.
   always @(posedge clk_i) begin
      #1;
      if (ready_rand) begin
         ready_bits = rand_next();
         rx_ready_i = ready_bits[3:0];
      end else begin
         rx_ready_i = 4'hf;
      end
   end

   task automatic wait_drain();
      while (pending != 0) @(posedge clk_i);
      repeat (2) @(posedge clk_i);
      #1;
   endtask

   initial begin
      repeat (WDOG_CYCLES) @(posedge clk_i);
      $display("watchdog: traffic did not drain within %0d cycles, the network looks hung",
               WDOG_CYCLES);
      $display("TEST FAIL");
      $finish;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      arst_n_i   = 1'b0;
      tx_valid_i = '0;
      tx_dest_i  = '0;
      tx_data_i  = '0;
      tx_last_i  = '0;
      rx_ready_i = 4'hf;
      ready_rand = 1'b0;
      rng_state  = 32'h3905_3a28;
      pending    = 0;
      data_errs  = 0;
      hdr_errs   = 0;
      last_errs  = 0;
      other_errs = 0;
      for (int i = 0; i < 4; i++) sent_cnt[i] = 0;
      repeat (3) @(posedge clk_i);
      #1 arst_n_i = 1'b1;

      // idle network, tx_ready_o waits for a header.
      repeat (4) begin
         @(negedge clk_i);
         check_ctrl(rx_valid_o, 4'h0, "rx_valid_o when idle");
         check_ctrl(tx_ready_o, 4'h0, "tx_ready_o when idle");
      end
      @(posedge clk_i);
      #1;

      fork
         send_pairs(0);
         send_pairs(1);
         send_pairs(2);
         send_pairs(3);
      join
      wait_drain();

      ready_rand = 1'b1;
      fork
         send_random(0, N_RAND, 1'b0);
         send_random(1, N_RAND, 1'b0);
         send_random(2, N_RAND, 1'b0);
         send_random(3, N_RAND, 1'b0);
      join
      wait_drain();

      // every tile into tile 0 at once.
      fork
         send_random(0, N_HOT, 1'b1);
         send_random(1, N_HOT, 1'b1);
         send_random(2, N_HOT, 1'b1);
         send_random(3, N_HOT, 1'b1);
      join
      wait_drain();

      for (int i = 0; i < 16; i++) begin
         if (exp_q[i].size() != 0) begin
            other_errs++;
            $display("%0d messages from tile %0d to tile %0d never arrived",
                     exp_q[i].size(), i / 4, i % 4);
         end
      end

      $display("errors: data %0d, header %0d, last %0d, other %0d",
               data_errs, hdr_errs, last_errs, other_errs);
      if (data_errs + hdr_errs + last_errs + other_errs == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== design/system_2x2_noc.sv ====
// 2x2 noc system
// mesh of four routers with one network adapter per tile port.
// tile ports are packed four wide, tile i in slice i.

`timescale 1ns/100ps

`include "noc_macros.svh"

module system_2x2_noc import noc_pkg::*; (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic [3:0]                   tx_valid_i,
   input  logic [7:0]                   tx_dest_i,
   input  logic [4*`NOC_FLIT_WIDTH-1:0] tx_data_i,
   input  logic [3:0]                   tx_last_i,
   output logic [3:0]                   tx_ready_o,
   output logic [3:0]                   rx_valid_o,
   output logic [7:0]                   rx_src_o,
   output logic [31:0]                  rx_seq_o,
   output logic [4*`NOC_FLIT_WIDTH-1:0] rx_data_o,
   output logic [3:0]                   rx_last_o,
   input  logic [3:0]                   rx_ready_i
);

   // adapter to mesh.
   flit_u a2m_flit  [4];
   logic  a2m_last  [4];
   logic  a2m_valid [4];
   logic  a2m_ready [4];
   // mesh to adapter.
   flit_u m2a_flit  [4];
   logic  m2a_last  [4];
   logic  m2a_valid [4];
   logic  m2a_ready [4];

   noc_mesh_2x2 u_mesh (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .in_flit_i   (a2m_flit),
      .in_last_i   (a2m_last),
      .in_valid_i  (a2m_valid),
      .in_ready_o  (a2m_ready),
      .out_flit_o  (m2a_flit),
      .out_last_o  (m2a_last),
      .out_valid_o (m2a_valid),
      .out_ready_i (m2a_ready)
   );

   for (genvar i = 0; i < 4; i++) begin : g_tile
      noc_tile_adapter #(
         .TILE_ID (i)
      ) u_adapter (
         .clk_i           (clk_i),
         .arst_n_i        (arst_n_i),
         .tx_valid_i      (tx_valid_i[i]),
         .tx_dest_i       (tx_dest_i[i*2 +: 2]),
         .tx_data_i       (tx_data_i[i*`NOC_FLIT_WIDTH +: `NOC_FLIT_WIDTH]),
         .tx_last_i       (tx_last_i[i]),
         .tx_ready_o      (tx_ready_o[i]),
         .rx_valid_o      (rx_valid_o[i]),
         .rx_src_o        (rx_src_o[i*2 +: 2]),
         .rx_seq_o        (rx_seq_o[i*8 +: 8]),
         .rx_data_o       (rx_data_o[i*`NOC_FLIT_WIDTH +: `NOC_FLIT_WIDTH]),
         .rx_last_o       (rx_last_o[i]),
         .rx_ready_i      (rx_ready_i[i]),
         .noc_out_flit_o  (a2m_flit[i]),
         .noc_out_last_o  (a2m_last[i]),
         .noc_out_valid_o (a2m_valid[i]),
         .noc_out_ready_i (a2m_ready[i]),
         .noc_in_flit_i   (m2a_flit[i]),
         .noc_in_last_i   (m2a_last[i]),
         .noc_in_valid_i  (m2a_valid[i]),
         .noc_in_ready_o  (m2a_ready[i])
      );
   end

endmodule

// ==== design/noc_tile_adapter.sv ====
// noc tile adapter
// transmit side puts a header flit in front of the tile payload.
// receive side strips the header and passes src and seq with the payload.

`timescale 1ns/100ps

`include "noc_macros.svh"

module noc_tile_adapter import noc_pkg::*; #(
   parameter int TILE_ID = 0
) (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       tx_valid_i,
   input  logic [1:0]                 tx_dest_i,
   input  logic [`NOC_FLIT_WIDTH-1:0] tx_data_i,
   input  logic                       tx_last_i,
   output logic                       tx_ready_o,
   output logic                       rx_valid_o,
   output logic [1:0]                 rx_src_o,
   output logic [7:0]                 rx_seq_o,
   output logic [`NOC_FLIT_WIDTH-1:0] rx_data_o,
   output logic                       rx_last_o,
   input  logic                       rx_ready_i,
   output flit_u                      noc_out_flit_o,
   output logic                       noc_out_last_o,
   output logic                       noc_out_valid_o,
   input  logic                       noc_out_ready_i,
   input  flit_u                      noc_in_flit_i,
   input  logic                       noc_in_last_i,
   input  logic                       noc_in_valid_i,
   output logic                       noc_in_ready_o
);

   localparam int CNT_W = $clog2(`NOC_MAX_PAYLOAD) + 1;

   logic             tx_pay_q;    // low while the header is pending.
   logic [7:0]       tx_seq_q;
   logic [CNT_W-1:0] tx_cnt_q;    // payload words sent so far.
   logic             tx_xfer;
   flit_u            tx_hdr;
   logic             rx_busy_q;
   logic [1:0]       rx_src_q;
   logic [7:0]       rx_seq_q;
   logic             rx_xfer;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // transmit
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      tx_hdr            = '0;
      tx_hdr.hdr.dest_x = tx_dest_i[0];   // tile id bit 0 is x.
      tx_hdr.hdr.dest_y = tx_dest_i[1];
      tx_hdr.hdr.src    = 2'(TILE_ID);
      tx_hdr.hdr.seq    = tx_seq_q;
   end

   always_comb begin
      noc_out_flit_o = tx_hdr;
      if (tx_pay_q) begin
         noc_out_flit_o.raw = tx_data_i;
      end
   end

   assign noc_out_valid_o = tx_valid_i;
   assign noc_out_last_o  = tx_pay_q & tx_last_i;
   assign tx_ready_o      = tx_pay_q & noc_out_ready_i;
   assign tx_xfer         = noc_out_valid_o & noc_out_ready_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tx_pay_q <= 1'b0;
         tx_seq_q <= '0;
         tx_cnt_q <= '0;
      end else if (tx_xfer) begin
         if (!tx_pay_q) begin
            tx_pay_q <= 1'b1;
            tx_cnt_q <= '0;
         end else if (tx_last_i) begin
            tx_pay_q <= 1'b0;
            tx_seq_q <= tx_seq_q + 8'd1;   // wraps at 256.
         end else begin
            tx_cnt_q <= tx_cnt_q + 1'b1;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // receive
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign noc_in_ready_o = rx_busy_q ? rx_ready_i : 1'b1;   // header always taken.
   assign rx_xfer        = noc_in_valid_i & noc_in_ready_o;
   assign rx_valid_o     = rx_busy_q & noc_in_valid_i;
   assign rx_data_o      = noc_in_flit_i.raw;
   assign rx_last_o      = noc_in_last_i;
   assign rx_src_o       = rx_src_q;
   assign rx_seq_o       = rx_seq_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rx_busy_q <= 1'b0;
      end else if (rx_xfer) begin
         rx_busy_q <= rx_busy_q ? !noc_in_last_i : 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rx_xfer && !rx_busy_q) begin
         rx_src_q <= noc_in_flit_i.hdr.src;
         rx_seq_q <= noc_in_flit_i.hdr.seq;
      end
   end

   // the tile holds its word until accepted.
   a_tx_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tx_valid_i && !tx_ready_o |=> tx_valid_i && $stable(tx_data_i) && $stable(tx_last_i));

   a_tx_max_len: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tx_xfer && tx_pay_q && (tx_cnt_q == CNT_W'(`NOC_MAX_PAYLOAD - 1)) |-> tx_last_i);

endmodule

// ==== design/noc_mesh_2x2.sv ====
// noc mesh 2x2
// four routers with their x and y neighbour links.

`timescale 1ns/100ps

`include "noc_macros.svh"

module noc_mesh_2x2 import noc_pkg::*; (
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  flit_u in_flit_i   [4],
   input  logic  in_last_i   [4],
   input  logic  in_valid_i  [4],
   output logic  in_ready_o  [4],
   output flit_u out_flit_o  [4],
   output logic  out_last_o  [4],
   output logic  out_valid_o [4],
   input  logic  out_ready_i [4]
);

   flit_u r_in_flit   [4][3];
   logic  r_in_last   [4][3];
   logic  r_in_valid  [4][3];
   logic  r_in_ready  [4][3];
   flit_u r_out_flit  [4][3];
   logic  r_out_last  [4][3];
   logic  r_out_valid [4][3];
   logic  r_out_ready [4][3];

   for (genvar i = 0; i < 4; i++) begin : g_node
      localparam int PX = i % `NOC_MESH_X;
      localparam int PY = i / `NOC_MESH_X;
      localparam int XN = (PX == 0) ? i + 1 : i - 1;   // x-neighbour.
      localparam int YN = (PY == `NOC_MESH_Y - 1) ? i - `NOC_MESH_X : i + `NOC_MESH_X;

      // local port to the adapter.
      assign r_in_flit[i][PORT_LOCAL]   = in_flit_i[i];
      assign r_in_last[i][PORT_LOCAL]   = in_last_i[i];
      assign r_in_valid[i][PORT_LOCAL]  = in_valid_i[i];
      assign in_ready_o[i]              = r_in_ready[i][PORT_LOCAL];
      assign out_flit_o[i]              = r_out_flit[i][PORT_LOCAL];
      assign out_last_o[i]              = r_out_last[i][PORT_LOCAL];
      assign out_valid_o[i]             = r_out_valid[i][PORT_LOCAL];
      assign r_out_ready[i][PORT_LOCAL] = out_ready_i[i];

      // neighbour links.
      assign r_in_flit[i][PORT_X]   = r_out_flit[XN][PORT_X];
      assign r_in_last[i][PORT_X]   = r_out_last[XN][PORT_X];
      assign r_in_valid[i][PORT_X]  = r_out_valid[XN][PORT_X];
      assign r_out_ready[i][PORT_X] = r_in_ready[XN][PORT_X];
      assign r_in_flit[i][PORT_Y]   = r_out_flit[YN][PORT_Y];
      assign r_in_last[i][PORT_Y]   = r_out_last[YN][PORT_Y];
      assign r_in_valid[i][PORT_Y]  = r_out_valid[YN][PORT_Y];
      assign r_out_ready[i][PORT_Y] = r_in_ready[YN][PORT_Y];

      noc_router #(
         .POS_X (PX),
         .POS_Y (PY)
      ) u_router (
         .clk_i       (clk_i),
         .arst_n_i    (arst_n_i),
         .in_flit_i   (r_in_flit[i]),
         .in_last_i   (r_in_last[i]),
         .in_valid_i  (r_in_valid[i]),
         .in_ready_o  (r_in_ready[i]),
         .out_flit_o  (r_out_flit[i]),
         .out_last_o  (r_out_last[i]),
         .out_valid_o (r_out_valid[i]),
         .out_ready_i (r_out_ready[i])
      );
   end

endmodule

// ==== design/noc_router/noc_router.sv ====
// noc router
// three port wormhole router with input buffers, XY routing and crossbar.
// port 0 is local, port 1 the x-link, port 2 the y-link.

`timescale 1ns/100ps

`include "noc_macros.svh"

module noc_router import noc_pkg::*; #(
   parameter int POS_X = 0,
   parameter int POS_Y = 0
) (
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  flit_u in_flit_i   [3],
   input  logic  in_last_i   [3],
   input  logic  in_valid_i  [3],
   output logic  in_ready_o  [3],
   output flit_u out_flit_o  [3],
   output logic  out_last_o  [3],
   output logic  out_valid_o [3],
   input  logic  out_ready_i [3]
);

   flit_u      buf_flit  [3];
   logic       buf_last  [3];
   logic       buf_valid [3];
   logic       buf_ready [3];
   logic       in_pkt_q  [3];   // input is inside a packet.
   port_idx_t  route_q   [3];
   port_idx_t  route     [3];
   logic [2:0] req       [3];   // per output, one bit per input.
   logic [2:0] gnt       [3];

   // dimension ordered, x first.
   function automatic port_idx_t xy_route(flit_u f);
      port_idx_t r;
      if (f.hdr.dest_x != 1'(POS_X)) begin
         r = PORT_X;
      end else if (f.hdr.dest_y != 1'(POS_Y)) begin
         r = PORT_Y;
      end else begin
         r = PORT_LOCAL;
      end
      return r;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // input side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   for (genvar i = 0; i < 3; i++) begin : g_in
      noc_buffer #(
         .DEPTH (`NOC_BUF_DEPTH)
      ) u_buf (
         .clk_i       (clk_i),
         .arst_n_i    (arst_n_i),
         .in_flit_i   (in_flit_i[i]),
         .in_last_i   (in_last_i[i]),
         .in_valid_i  (in_valid_i[i]),
         .in_ready_o  (in_ready_o[i]),
         .out_flit_o  (buf_flit[i]),
         .out_last_o  (buf_last[i]),
         .out_valid_o (buf_valid[i]),
         .out_ready_i (buf_ready[i])
      );

      // the head of a new packet is its header.
      assign route[i] = in_pkt_q[i] ? route_q[i] : xy_route(buf_flit[i]);

      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            in_pkt_q[i] <= 1'b0;
            route_q[i]  <= PORT_LOCAL;
         end else if (buf_valid[i] && buf_ready[i]) begin
            in_pkt_q[i] <= !buf_last[i];
            if (!in_pkt_q[i]) begin
               route_q[i] <= route[i];   // held until last.
            end
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // output side and crossbar
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   for (genvar o = 0; o < 3; o++) begin : g_out
      always_comb begin
         for (int i = 0; i < 3; i++) begin
            req[o][i] = buf_valid[i] && (route[i] == port_idx_t'(o));
         end
      end

      noc_out_arbiter u_arb (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .req_i    (req[o]),
         .last_i   (out_last_o[o]),
         .xfer_i   (out_valid_o[o] && out_ready_i[o]),
         .gnt_o    (gnt[o])
      );

      always_comb begin
         out_flit_o[o]  = buf_flit[0];
         out_last_o[o]  = 1'b0;
         out_valid_o[o] = 1'b0;
         for (int i = 0; i < 3; i++) begin
            if (gnt[o][i]) begin
               out_flit_o[o]  = buf_flit[i];
               out_last_o[o]  = buf_last[i];
               out_valid_o[o] = buf_valid[i];
            end
         end
      end
   end

   // an input pops when its granted output accepts.
   always_comb begin
      for (int i = 0; i < 3; i++) begin
         buf_ready[i] = 1'b0;
         for (int o = 0; o < 3; o++) begin
            buf_ready[i] = buf_ready[i] | (gnt[o][i] & out_ready_i[o]);
         end
      end
   end

endmodule

// ==== design/noc_router/noc_out_arbiter.sv ====
// noc output arbiter
// round-robin grant per router output, locked for a whole packet.

`timescale 1ns/100ps

module noc_out_arbiter import noc_pkg::*; (
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic [2:0] req_i,
   input  logic       last_i,    // last bit of the granted flit.
   input  logic       xfer_i,    // flit moved on this output.
   output logic [2:0] gnt_o
);

   typedef enum logic {
      ARB_IDLE,
      ARB_LOCKED
   } arb_state_e;

   arb_state_e state_q;
   port_idx_t  ptr_q;       // last granted input.
   port_idx_t  pick_idx;
   logic       pick_vld;
   logic [2:0] gnt_q;

   // search the requesters, starting after the pointer.
   always_comb begin
      port_idx_t idx;
      idx      = ptr_q;
      pick_idx = ptr_q;
      pick_vld = 1'b0;
      for (int k = 0; k < 3; k++) begin
         idx = (idx == 2'd2) ? 2'd0 : idx + 2'd1;
         if (req_i[idx] && !pick_vld) begin
            pick_idx = idx;
            pick_vld = 1'b1;
         end
      end
   end

   assign gnt_o = (state_q == ARB_LOCKED) ? gnt_q :
                  pick_vld ? (3'b001 << pick_idx) : 3'b000;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // grant state machine
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ARB_IDLE;
         ptr_q   <= PORT_LOCAL;
         gnt_q   <= '0;
      end else begin
         case (state_q)
            ARB_IDLE: begin
               if (pick_vld) begin
                  ptr_q <= pick_idx;
                  gnt_q <= gnt_o;
                  if (!(xfer_i && last_i)) begin
                     state_q <= ARB_LOCKED;   // a single flit packet stays idle.
                  end
               end
            end
            ARB_LOCKED: begin
               if (xfer_i && last_i) begin
                  state_q <= ARB_IDLE;
               end
            end
            default: state_q <= ARB_IDLE;
         endcase
      end
   end

   // a flit only moves on an output that holds a grant.
   a_xfer_granted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      xfer_i |-> (gnt_o != 3'b000));

endmodule

// ==== design/noc_router/noc_buffer.sv ====
// noc buffer
// circular flit FIFO at a router input, head always on the output.

`timescale 1ns/100ps

module noc_buffer import noc_pkg::*; #(
   parameter int DEPTH = 4
) (
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  flit_u in_flit_i,
   input  logic  in_last_i,
   input  logic  in_valid_i,
   output logic  in_ready_o,
   output flit_u out_flit_o,
   output logic  out_last_o,
   output logic  out_valid_o,
   input  logic  out_ready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   flit_u            mem_flit [DEPTH];
   logic             mem_last [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             wr_en;
   logic             rd_en;

   assign in_ready_o  = (count_q != CNT_W'(DEPTH));   // full at DEPTH.
   assign out_valid_o = (count_q != '0);
   assign out_flit_o  = mem_flit[rd_ptr_q];
   assign out_last_o  = mem_last[rd_ptr_q];

   assign wr_en = in_valid_i & in_ready_o;
   assign rd_en = out_valid_o & out_ready_i;

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem_flit[wr_ptr_q] <= in_flit_i;
         mem_last[wr_ptr_q] <= in_last_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // a flit refused by a full buffer is held by the sender until taken.
   a_refused_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_flit_i) && $stable(in_last_i));

endmodule

// ==== common/noc_pkg.sv ====
// noc package
// flit and router port types shared by routers, mesh and adapters.

`include "noc_macros.svh"

package noc_pkg;

   // header view of a flit.
   typedef struct packed {
      logic                          dest_x;
      logic                          dest_y;
      logic [1:0]                    src;       // source tile id.
      logic [7:0]                    seq;
      logic [`NOC_FLIT_WIDTH-13:0]   reserved;
   } noc_hdr_t;

   // one link word, read as a header or as payload.
   typedef union packed {
      noc_hdr_t                   hdr;
      logic [`NOC_FLIT_WIDTH-1:0] raw;
   } flit_u;

   typedef logic [1:0] port_idx_t;

   localparam port_idx_t PORT_LOCAL = 2'd0;
   localparam port_idx_t PORT_X     = 2'd1;   // link to the x-neighbour.
   localparam port_idx_t PORT_Y     = 2'd2;   // link to the y-neighbour.

endpackage

// ==== common/noc_macros.svh ====
// noc sizes
// global dimensions of the 2x2 mesh network.

`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

`define NOC_FLIT_WIDTH  32  // bits per flit.
`define NOC_MESH_X      2
`define NOC_MESH_Y      2
`define NOC_BUF_DEPTH   4   // flits per router input.
`define NOC_MAX_PAYLOAD 4   // payload words per packet.

`endif
